/* all.f */
+incdir+include
logic/rx_pkg.sv
logic/coef_store.sv
logic/sample_history.sv
logic/ffe_filter.sv
logic/bit_slicer.sv
logic/mlsd_checker.sv
logic/forward_path.sv
tests/forward_path_tb.sv

/* include/rx_config.svh */
`ifndef RX_CONFIG_SVH
`define RX_CONFIG_SVH

// samples per word, lane 0 is the oldest.
`define RX_LANES 4

`define RX_CODE_W 8 // adc code width.

// feed-forward equalizer.
`define RX_FFE_TAPS 3
`define RX_W_W 8
`define RX_FFE_OUT_W 10

// shared by the ffe shift and the checker shift.
`define RX_SHIFT_W 4

`define RX_THR_W 10 // slicer threshold width.

// channel estimate used by the sequence checker.
`define RX_EST_DEPTH 3
`define RX_EST_W 8

`endif

/* logic/bit_slicer.sv */
`timescale 1ns/1ns
`include "rx_config.svh"

module bit_slicer (
	input wire logic clk,
	input wire logic rstb,

	input wire rx_pkg::ffe_out_t equalized_i [`RX_LANES-1:0],
	input wire rx_pkg::thresh_t thresh_i [`RX_LANES-1:0],

	output logic bits_o [`RX_LANES-1:0],
	output logic prev_bits_o [`RX_LANES-1:0]
);

	logic bits_next [`RX_LANES-1:0];

	// strictly above threshold decides a one.
	always_comb begin
		for (int j = 0; j < `RX_LANES; j++) begin
			bits_next[j] = equalized_i[j] > thresh_i[j];
		end
	end

	// previous word kept so the checker can reach back across the word edge.
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			for (int j = 0; j < `RX_LANES; j++) begin
				bits_o[j] <= 1'b0;
				prev_bits_o[j] <= 1'b0;
			end
		end else begin
			for (int j = 0; j < `RX_LANES; j++) begin
				bits_o[j] <= bits_next[j];
				prev_bits_o[j] <= bits_o[j];
			end
		end
	end

endmodule : bit_slicer

/* logic/coef_store.sv */
`timescale 1ns/1ns
`include "rx_config.svh"

module coef_store (
	input wire logic clk,
	input wire logic rstb,

	input wire rx_pkg::weight_t new_weights_i [`RX_FFE_TAPS-1:0][`RX_LANES-1:0],
	input wire logic update_weights_i [`RX_FFE_TAPS-1:0][`RX_LANES-1:0],
	input wire rx_pkg::shift_t new_ffe_shift_i [`RX_LANES-1:0],
	input wire logic update_ffe_shift_i [`RX_LANES-1:0],
	input wire rx_pkg::thresh_t new_thresh_i [`RX_LANES-1:0],
	input wire logic update_thresh_i [`RX_LANES-1:0],
	input wire rx_pkg::est_t new_est_i [`RX_LANES-1:0][`RX_EST_DEPTH-1:0],
	input wire logic update_est_i [`RX_LANES-1:0][`RX_EST_DEPTH-1:0],
	input wire rx_pkg::shift_t new_mlsd_shift_i [`RX_LANES-1:0],
	input wire logic update_mlsd_shift_i [`RX_LANES-1:0],

	output rx_pkg::weight_t weights_o [`RX_FFE_TAPS-1:0][`RX_LANES-1:0],
	output rx_pkg::shift_t ffe_shift_o [`RX_LANES-1:0],
	output rx_pkg::thresh_t thresh_o [`RX_LANES-1:0],
	output rx_pkg::est_t est_o [`RX_LANES-1:0][`RX_EST_DEPTH-1:0],
	output rx_pkg::shift_t mlsd_shift_o [`RX_LANES-1:0]
);

	// each coefficient holds until its own strobe loads a new value.
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			for (int i = 0; i < `RX_LANES; i++) begin
				ffe_shift_o[i] <= '0;
				thresh_o[i] <= '0;
				mlsd_shift_o[i] <= '0;
				for (int k = 0; k < `RX_FFE_TAPS; k++) begin
					weights_o[k][i] <= '0;
				end
				for (int k = 0; k < `RX_EST_DEPTH; k++) begin
					est_o[i][k] <= '0;
				end
			end
		end else begin
			for (int i = 0; i < `RX_LANES; i++) begin
				if (update_ffe_shift_i[i])
					ffe_shift_o[i] <= new_ffe_shift_i[i];
				if (update_thresh_i[i])
					thresh_o[i] <= new_thresh_i[i];
				if (update_mlsd_shift_i[i])
					mlsd_shift_o[i] <= new_mlsd_shift_i[i];
				for (int k = 0; k < `RX_FFE_TAPS; k++) begin
					if (update_weights_i[k][i])
						weights_o[k][i] <= new_weights_i[k][i]; // tap k, lane i.
				end
				for (int k = 0; k < `RX_EST_DEPTH; k++) begin
					if (update_est_i[i][k])
						est_o[i][k] <= new_est_i[i][k];
				end
			end
		end
	end

endmodule : coef_store

/* logic/ffe_filter.sv */
`timescale 1ns/1ns
`include "rx_config.svh"

module ffe_filter (
	input wire logic clk,
	input wire logic rstb,

	input wire rx_pkg::code_t cur_codes_i [`RX_LANES-1:0],
	input wire rx_pkg::code_t past_codes_i [`RX_LANES-1:0],
	input wire rx_pkg::weight_t weights_i [`RX_FFE_TAPS-1:0][`RX_LANES-1:0],
	input wire rx_pkg::shift_t ffe_shift_i [`RX_LANES-1:0],

	output rx_pkg::ffe_out_t equalized_o [`RX_LANES-1:0]
);

	// product width plus two guard bits for the three tap sum.
	localparam int ACC_W = `RX_CODE_W + `RX_W_W + 2;
	localparam int OUT_W = `RX_FFE_OUT_W;

	rx_pkg::code_t window [2*`RX_LANES-1:0];
	rx_pkg::ffe_out_t eq_next [`RX_LANES-1:0];

	// flat window, past word below the current word.
	always_comb begin
		for (int i = 0; i < `RX_LANES; i++) begin
			window[i] = past_codes_i[i];
			window[`RX_LANES+i] = cur_codes_i[i];
		end
	end

	always_comb begin
		logic signed [ACC_W-1:0] acc;
		logic signed [ACC_W-1:0] shifted;
		logic fits;

		for (int j = 0; j < `RX_LANES; j++) begin
			acc = '0;
			for (int k = 0; k < `RX_FFE_TAPS; k++) begin
				acc = acc + ACC_W'(window[`RX_LANES+j-k]) * ACC_W'(weights_i[k][j]);
			end
			shifted = acc >>> ffe_shift_i[j];
			// in range when every bit above the output sign matches it.
			fits = (&shifted[ACC_W-1:OUT_W-1]) || !(|shifted[ACC_W-1:OUT_W-1]);
			if (fits)
				eq_next[j] = shifted[OUT_W-1:0];
			else if (shifted[ACC_W-1])
				eq_next[j] = {1'b1, {(OUT_W-1){1'b0}}}; // most negative.
			else
				eq_next[j] = {1'b0, {(OUT_W-1){1'b1}}}; // most positive.
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			for (int j = 0; j < `RX_LANES; j++) begin
				equalized_o[j] <= '0;
			end
		end else begin
			for (int j = 0; j < `RX_LANES; j++) begin
				equalized_o[j] <= eq_next[j];
			end
		end
	end

endmodule : ffe_filter

/* logic/forward_path.sv */
`timescale 1ns/1ns
`include "rx_config.svh"

module forward_path (
	input wire logic clk,
	input wire logic rstb,

	input wire rx_pkg::code_t codes_i [`RX_LANES-1:0],

	input wire rx_pkg::weight_t new_weights_i [`RX_FFE_TAPS-1:0][`RX_LANES-1:0],
	input wire logic update_weights_i [`RX_FFE_TAPS-1:0][`RX_LANES-1:0],
	input wire rx_pkg::shift_t new_ffe_shift_i [`RX_LANES-1:0],
	input wire logic update_ffe_shift_i [`RX_LANES-1:0],
	input wire rx_pkg::thresh_t new_thresh_i [`RX_LANES-1:0],
	input wire logic update_thresh_i [`RX_LANES-1:0],
	input wire rx_pkg::est_t new_est_i [`RX_LANES-1:0][`RX_EST_DEPTH-1:0],
	input wire logic update_est_i [`RX_LANES-1:0][`RX_EST_DEPTH-1:0],
	input wire rx_pkg::shift_t new_mlsd_shift_i [`RX_LANES-1:0],
	input wire logic update_mlsd_shift_i [`RX_LANES-1:0],

	output logic checked_bits_o [`RX_LANES-1:0]
);

	rx_pkg::weight_t weights [`RX_FFE_TAPS-1:0][`RX_LANES-1:0];
	rx_pkg::shift_t ffe_shift [`RX_LANES-1:0];
	rx_pkg::thresh_t thresh [`RX_LANES-1:0];
	rx_pkg::est_t est [`RX_LANES-1:0][`RX_EST_DEPTH-1:0];
	rx_pkg::shift_t mlsd_shift [`RX_LANES-1:0];

	rx_pkg::code_t cur_codes [`RX_LANES-1:0];
	rx_pkg::code_t past_codes [`RX_LANES-1:0];
	rx_pkg::code_t delayed_codes [`RX_LANES-1:0];
	rx_pkg::ffe_out_t equalized [`RX_LANES-1:0];
	logic bits [`RX_LANES-1:0];
	logic prev_bits [`RX_LANES-1:0];

	coef_store coef_store0 (
		.clk(clk), .rstb(rstb),
		.new_weights_i(new_weights_i), .update_weights_i(update_weights_i),
		.new_ffe_shift_i(new_ffe_shift_i), .update_ffe_shift_i(update_ffe_shift_i),
		.new_thresh_i(new_thresh_i), .update_thresh_i(update_thresh_i),
		.new_est_i(new_est_i), .update_est_i(update_est_i),
		.new_mlsd_shift_i(new_mlsd_shift_i), .update_mlsd_shift_i(update_mlsd_shift_i),
		.weights_o(weights), .ffe_shift_o(ffe_shift), .thresh_o(thresh),
		.est_o(est), .mlsd_shift_o(mlsd_shift)
	);

	sample_history sample_history0 (
		.clk(clk), .rstb(rstb), .codes_i(codes_i),
		.cur_codes_o(cur_codes), .past_codes_o(past_codes),
		.delayed_codes_o(delayed_codes)
	);

	// equalized word lands one cycle after the codes.
	ffe_filter ffe_filter0 (
		.clk(clk), .rstb(rstb),
		.cur_codes_i(cur_codes), .past_codes_i(past_codes),
		.weights_i(weights), .ffe_shift_i(ffe_shift),
		.equalized_o(equalized)
	);

	bit_slicer bit_slicer0 (
		.clk(clk), .rstb(rstb),
		.equalized_i(equalized), .thresh_i(thresh),
		.bits_o(bits), .prev_bits_o(prev_bits)
	);

	mlsd_checker mlsd_checker0 (
		.clk(clk), .rstb(rstb),
		.codes_i(delayed_codes), .bits_i(bits), .prev_bits_i(prev_bits),
		.est_i(est), .mlsd_shift_i(mlsd_shift),
		.checked_bits_o(checked_bits_o)
	);

endmodule : forward_path

/* logic/mlsd_checker.sv */
`timescale 1ns/1ns
`include "rx_config.svh"

module mlsd_checker (
	input wire logic clk,
	input wire logic rstb,

	input wire rx_pkg::code_t codes_i [`RX_LANES-1:0],
	input wire logic bits_i [`RX_LANES-1:0],
	input wire logic prev_bits_i [`RX_LANES-1:0],
	input wire rx_pkg::est_t est_i [`RX_LANES-1:0][`RX_EST_DEPTH-1:0],
	input wire rx_pkg::shift_t mlsd_shift_i [`RX_LANES-1:0],

	output logic checked_bits_o [`RX_LANES-1:0]
);

	// sum of three plus or minus estimate taps.
	localparam int PRED_W = `RX_EST_W + 2;
	localparam int ERR_W = PRED_W + 2;

	logic bit_window [2*`RX_LANES-1:0];
	logic decision [`RX_LANES-1:0];

	always_comb begin
		for (int i = 0; i < `RX_LANES; i++) begin
			bit_window[i] = prev_bits_i[i];
			bit_window[`RX_LANES+i] = bits_i[i];
		end
	end

	always_comb begin
		logic signed [PRED_W-1:0] tail;
		logic signed [PRED_W-1:0] pred_one;
		logic signed [PRED_W-1:0] pred_zero;
		logic signed [ERR_W-1:0] diff_one;
		logic signed [ERR_W-1:0] diff_zero;
		logic signed [ERR_W-1:0] err_one;
		logic signed [ERR_W-1:0] err_zero;

		for (int j = 0; j < `RX_LANES; j++) begin
			// older symbols come from the slicer.
			tail = '0;
			for (int k = 1; k < `RX_EST_DEPTH; k++) begin
				if (bit_window[`RX_LANES+j-k])
					tail = tail + PRED_W'(est_i[j][k]);
				else
					tail = tail - PRED_W'(est_i[j][k]);
			end
			pred_one = (tail + PRED_W'(est_i[j][0])) >>> mlsd_shift_i[j];
			pred_zero = (tail - PRED_W'(est_i[j][0])) >>> mlsd_shift_i[j];

			diff_one = ERR_W'(codes_i[j]) - ERR_W'(pred_one);
			diff_zero = ERR_W'(codes_i[j]) - ERR_W'(pred_zero);
			err_one = diff_one[ERR_W-1] ? -diff_one : diff_one;
			err_zero = diff_zero[ERR_W-1] ? -diff_zero : diff_zero;

			if (err_one < err_zero)
				decision[j] = 1'b1;
			else if (err_zero < err_one)
				decision[j] = 1'b0;
			else
				decision[j] = bits_i[j]; // tie, trust the slicer.
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			for (int j = 0; j < `RX_LANES; j++) begin
				checked_bits_o[j] <= 1'b0;
			end
		end else begin
			for (int j = 0; j < `RX_LANES; j++) begin
				checked_bits_o[j] <= decision[j];
			end
		end
	end

endmodule : mlsd_checker

/* logic/rx_pkg.sv */
`include "rx_config.svh"

package rx_pkg;

	// signed data words.
	typedef logic signed [`RX_CODE_W-1:0] code_t;
	typedef logic signed [`RX_FFE_OUT_W-1:0] ffe_out_t;

	// coefficients.
	typedef logic signed [`RX_W_W-1:0] weight_t;
	typedef logic signed [`RX_THR_W-1:0] thresh_t;
	typedef logic signed [`RX_EST_W-1:0] est_t;

	typedef logic [`RX_SHIFT_W-1:0] shift_t; // right shift amount.

endpackage : rx_pkg

/* logic/sample_history.sv */
`timescale 1ns/1ns
`include "rx_config.svh"

module sample_history (
	input wire logic clk,
	input wire logic rstb,

	input wire rx_pkg::code_t codes_i [`RX_LANES-1:0],

	output rx_pkg::code_t cur_codes_o [`RX_LANES-1:0],
	output rx_pkg::code_t past_codes_o [`RX_LANES-1:0],
	output rx_pkg::code_t delayed_codes_o [`RX_LANES-1:0]
);

	// three word shift register.
	// cur and past form the equalizer window, delayed lines up with the slicer bits.
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			for (int i = 0; i < `RX_LANES; i++) begin
				cur_codes_o[i] <= '0;
				past_codes_o[i] <= '0;
				delayed_codes_o[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `RX_LANES; i++) begin
				cur_codes_o[i] <= codes_i[i];
				past_codes_o[i] <= cur_codes_o[i];
				delayed_codes_o[i] <= past_codes_o[i]; // word from two cycles back.
			end
		end
	end

endmodule : sample_history

/* run.sh */
#!/bin/bash
# builds the testbench with Verilator, runs it and searches the log for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -f all.f \
	--top-module forward_path_tb -o forward_path_sim

./obj_dir/forward_path_sim | tee sim.log

grep -qx "No errors" sim.log

/* tests/forward_path_tb.sv */
`timescale 1ns/1ns
`include "rx_config.svh"

module forward_path_tb;

	localparam int LANES = `RX_LANES;
	localparam int TAPS = `RX_FFE_TAPS;
	localparam int DEPTH = `RX_EST_DEPTH;
	localparam int RUN_CYCLES = 200;
	localparam int SAT_CYCLES = 60;
	// reset and zero input, the three streams with their two load cycles and the saturation runs.
	localparam int TOTAL_CYCLES = 7 + 3 * RUN_CYCLES + 2 + 2 * (SAT_CYCLES + 1);
	localparam int WATCHDOG_NS = (TOTAL_CYCLES + 50) * 4;
	localparam int SAT_HI = (1 << (`RX_FFE_OUT_W - 1)) - 1;
	localparam int SAT_LO = -SAT_HI - 1;

	logic clk;
	logic rstb;
	rx_pkg::code_t codes [LANES-1:0];
	rx_pkg::weight_t new_weights [TAPS-1:0][LANES-1:0];
	logic update_weights [TAPS-1:0][LANES-1:0];
	rx_pkg::shift_t new_ffe_shift [LANES-1:0];
	logic update_ffe_shift [LANES-1:0];
	rx_pkg::thresh_t new_thresh [LANES-1:0];
	logic update_thresh [LANES-1:0];
	rx_pkg::est_t new_est [LANES-1:0][DEPTH-1:0];
	logic update_est [LANES-1:0][DEPTH-1:0];
	rx_pkg::shift_t new_mlsd_shift [LANES-1:0];
	logic update_mlsd_shift [LANES-1:0];
	logic checked_bits [LANES-1:0];

	// model copy of every DUT register.
	int m_w [TAPS][LANES];
	int m_fs [LANES];
	int m_thr [LANES];
	int m_est [LANES][DEPTH];
	int m_ms [LANES];
	int m_cur [LANES];
	int m_past [LANES];
	int m_delayed [LANES];
	int m_eq [LANES];
	logic m_bits [LANES];
	logic m_prev [LANES];
	logic m_checked [LANES-1:0];
	int corrections = 0;
	int checks = 0;
	int errors = 0;

	forward_path dut0 (
		.clk(clk), .rstb(rstb), .codes_i(codes),
		.new_weights_i(new_weights), .update_weights_i(update_weights),
		.new_ffe_shift_i(new_ffe_shift), .update_ffe_shift_i(update_ffe_shift),
		.new_thresh_i(new_thresh), .update_thresh_i(update_thresh),
		.new_est_i(new_est), .update_est_i(update_est),
		.new_mlsd_shift_i(new_mlsd_shift), .update_mlsd_shift_i(update_mlsd_shift),
		.checked_bits_o(checked_bits)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic int symbol(logic b);
		return b ? 1 : -1;
	endfunction

	function automatic int magnitude(int v);
		return v < 0 ? -v : v;
	endfunction

	// expected code for symbols s0 (newest), s1 and s2.
	function automatic int predict(int lane, int s0, int s1, int s2);
		return (m_est[lane][0] * s0 + m_est[lane][1] * s1 + m_est[lane][2] * s2)
			>>> m_ms[lane];
	endfunction

	function automatic logic [LANES-1:0] pack(logic b [LANES-1:0]);
		logic [LANES-1:0] v;
		for (int j = 0; j < LANES; j++)
			v[j] = b[j];
		return v;
	endfunction

	task automatic advance_model();
		logic win [2*LANES];
		int xs [2*LANES];
		int p_one;
		int p_zero;
		int e_one;
		int e_zero;
		int acc;
		for (int i = 0; i < LANES; i++) begin
			win[i] = m_prev[i];
			win[LANES+i] = m_bits[i];
			xs[i] = m_past[i];
			xs[LANES+i] = m_cur[i];
		end
		for (int j = 0; j < LANES; j++) begin
			p_one = predict(j, 1, symbol(win[LANES+j-1]), symbol(win[LANES+j-2]));
			p_zero = predict(j, -1, symbol(win[LANES+j-1]), symbol(win[LANES+j-2]));
			e_one = magnitude(m_delayed[j] - p_one);
			e_zero = magnitude(m_delayed[j] - p_zero);
			m_checked[j] = (e_one == e_zero) ? m_bits[j] : (e_one < e_zero);
			if (m_checked[j] != m_bits[j])
				corrections++;
			m_prev[j] = m_bits[j];
			m_bits[j] = m_eq[j] > m_thr[j];
			acc = 0;
			for (int k = 0; k < TAPS; k++)
				acc += m_w[k][j] * xs[LANES+j-k]; // x(n-k) across the word edge.
			acc = acc >>> m_fs[j];
			m_eq[j] = acc > SAT_HI ? SAT_HI : (acc < SAT_LO ? SAT_LO : acc);
			m_delayed[j] = m_past[j];
			m_past[j] = m_cur[j];
			m_cur[j] = int'(codes[j]);
			if (update_ffe_shift[j])
				m_fs[j] = int'(new_ffe_shift[j]);
			if (update_thresh[j])
				m_thr[j] = int'(new_thresh[j]);
			if (update_mlsd_shift[j])
				m_ms[j] = int'(new_mlsd_shift[j]);
			for (int k = 0; k < TAPS; k++)
				if (update_weights[k][j])
					m_w[k][j] = int'(new_weights[k][j]);
			for (int k = 0; k < DEPTH; k++)
				if (update_est[j][k])
					m_est[j][k] = int'(new_est[j][k]);
		end
	endtask

	always @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			m_w = '{default: 0};
			m_fs = '{default: 0};
			m_thr = '{default: 0};
			m_est = '{default: 0};
			m_ms = '{default: 0};
			m_cur = '{default: 0};
			m_past = '{default: 0};
			m_delayed = '{default: 0};
			m_eq = '{default: 0};
			m_bits = '{default: 1'b0};
			m_prev = '{default: 1'b0};
			m_checked = '{default: 1'b0};
		end else begin
			advance_model();
		end
	end

	task automatic compare(string name, logic [LANES-1:0] expected, logic [LANES-1:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Mismatch %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic strobe_all(logic ffe, logic est);
		update_weights = '{default: ffe};
		update_ffe_shift = '{default: ffe};
		update_thresh = '{default: ffe};
		update_est = '{default: est};
		update_mlsd_shift = '{default: est};
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
		compare("checked_bits_o", pack(m_checked), pack(checked_bits));
		strobe_all(1'b0, 1'b0);
	endtask

	// new codes every cycle while coefficient values only matter where a strobe is set.
	task automatic randomize_inputs(logic extreme, int shift_lo, int shift_hi);
		for (int j = 0; j < LANES; j++) begin
			codes[j] = extreme ? ($urandom_range(0, 1) ? 8'h7f : 8'h80)
				: rx_pkg::code_t'($urandom);
			new_ffe_shift[j] = rx_pkg::shift_t'($urandom_range(shift_lo, shift_hi));
			new_thresh[j] = rx_pkg::thresh_t'(int'($urandom_range(0, 400)) - 200);
			new_mlsd_shift[j] = rx_pkg::shift_t'($urandom_range(0, 2));
			for (int k = 0; k < TAPS; k++)
				new_weights[k][j] = extreme ? ($urandom_range(0, 1) ? 8'h7f : 8'h80)
					: rx_pkg::weight_t'($urandom);
			for (int k = 0; k < DEPTH; k++)
				new_est[j][k] = rx_pkg::est_t'(int'($urandom_range(0, 160)) - 80);
		end
	endtask

	task automatic write_single();
		int lane;
		int tap;
		lane = int'($urandom_range(0, LANES - 1));
		tap = int'($urandom_range(0, 7));
		case ($urandom_range(0, 4))
			0: update_weights[tap % TAPS][lane] = 1'b1;
			1: update_ffe_shift[lane] = 1'b1;
			2: update_thresh[lane] = 1'b1;
			3: update_est[lane][tap % DEPTH] = 1'b1;
			default: update_mlsd_shift[lane] = 1'b1;
		endcase
	endtask

	task automatic run_stream(int cycles, logic extreme, int shift_lo, int shift_hi,
		logic singles);
		for (int c = 0; c < cycles; c++) begin
			randomize_inputs(extreme, shift_lo, shift_hi);
			if (singles && c % 4 == 0)
				write_single();
			next_cycle();
		end
	endtask

	task automatic end_test(string name, int base);
		$display("%s: %0d errors", name, errors - base);
	endtask

	initial begin
		int base;
		int base_corr;
		void'($urandom(32'h95e1));
		rstb = 1'b0;
		codes = '{default: '0};
		new_weights = '{default: '0};
		new_ffe_shift = '{default: '0};
		new_thresh = '{default: '0};
		new_est = '{default: '0};
		new_mlsd_shift = '{default: '0};
		strobe_all(1'b0, 1'b0);
		repeat (4) next_cycle();
		rstb = 1'b1;
		repeat (3) begin
			next_cycle();
			compare("checked_bits_o", '0, pack(checked_bits));
		end
		end_test("reset", 0);

		// estimate is still zero so every tie keeps the slicer bit.
		base = errors;
		randomize_inputs(1'b0, 0, 8);
		strobe_all(1'b1, 1'b0);
		next_cycle();
		run_stream(RUN_CYCLES, 1'b0, 0, 8, 1'b0);
		end_test("equalizer and slicer", base);

		base = errors;
		base_corr = corrections;
		randomize_inputs(1'b0, 0, 6);
		strobe_all(1'b1, 1'b1);
		next_cycle();
		run_stream(RUN_CYCLES, 1'b0, 0, 6, 1'b0);
		if (corrections == base_corr) begin
			errors++;
			$display("checker test produced no bit that differs from the slicer");
		end
		end_test("checker correction", base);

		base = errors;
		run_stream(RUN_CYCLES, 1'b0, 0, 8, 1'b1);
		end_test("strobe writes", base);

		base = errors;
		randomize_inputs(1'b1, 0, 0);
		new_est = '{default: '0};
		strobe_all(1'b1, 1'b1);
		next_cycle();
		run_stream(SAT_CYCLES, 1'b1, 0, 0, 1'b0);
		randomize_inputs(1'b1, 15, 15); // maximum shift.
		// shifted sums land between -2 and 1, so the thresholds sit at 0 and -1.
		for (int j = 0; j < LANES; j++)
			new_thresh[j] = rx_pkg::thresh_t'(-(j % 2));
		strobe_all(1'b1, 1'b0);
		next_cycle();
		run_stream(SAT_CYCLES, 1'b1, 15, 15, 1'b0);
		end_test("saturation and shifts", base);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout, the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Errors found");
		$finish;
	end

endmodule : forward_path_tb
